// ==== Makefile ====
# Verilator build for the AXI-Lite router testbench

VERILATOR ?= verilator
TOP       ?= axil_router_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
EXTRA     ?=

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench makes the binary, and so make, exit non-zero
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== source/axil_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_router
  import axil_router_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  input  wire logic                  host_awvalid,
  input  wire host_aw_t              host_aw,
  output      logic                  host_awready,
  input  wire logic                  host_wvalid,
  input  wire w_beat_t               host_w,
  output      logic                  host_wready,
  output      logic                  host_bvalid,
  output      b_beat_t               host_b,
  input  wire logic                  host_bready,

  input  wire logic                  host_arvalid,
  input  wire host_ar_t              host_ar,
  output      logic                  host_arready,
  output      logic                  host_rvalid,
  output      r_beat_t               host_r,
  input  wire logic                  host_rready,

  output      logic    [NUM_SUB-1:0] sub_awvalid,
  output      sub_aw_t [NUM_SUB-1:0] sub_aw,
  input  wire logic    [NUM_SUB-1:0] sub_awready,
  output      logic    [NUM_SUB-1:0] sub_wvalid,
  output      w_beat_t [NUM_SUB-1:0] sub_w,
  input  wire logic    [NUM_SUB-1:0] sub_wready,
  input  wire logic    [NUM_SUB-1:0] sub_bvalid,
  input  wire b_beat_t [NUM_SUB-1:0] sub_b,
  output      logic    [NUM_SUB-1:0] sub_bready,

  output      logic    [NUM_SUB-1:0] sub_arvalid,
  output      sub_ar_t [NUM_SUB-1:0] sub_ar,
  input  wire logic    [NUM_SUB-1:0] sub_arready,
  input  wire logic    [NUM_SUB-1:0] sub_rvalid,
  input  wire r_beat_t [NUM_SUB-1:0] sub_r,
  output      logic    [NUM_SUB-1:0] sub_rready
);

  // Reads and writes share nothing but the clock and reset
  axil_router_wr wr_router_i (.*);

  axil_router_rd rd_router_i (.*);

endmodule

`default_nettype wire

// ==== source/axil_router_pkg.sv ====
`default_nettype none

package axil_router_pkg;

  // Three subordinates, so select value 3 is left unmapped
  localparam int NUM_SUB     = 3;
  localparam int SEL_W       = 2;
  localparam int HOST_ADDR_W = 30;
  localparam int SUB_ADDR_W  = HOST_ADDR_W - SEL_W;
  localparam int DATA_W      = 32;
  localparam int STRB_W      = DATA_W / 8;

  typedef logic [HOST_ADDR_W-1:0] host_addr_t;
  typedef logic [SUB_ADDR_W-1:0]  sub_addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [STRB_W-1:0]      strb_t;
  typedef logic [1:0]             resp_t;
  typedef logic [SEL_W-1:0]       sub_sel_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

  typedef struct packed {
    host_addr_t addr;
  } host_aw_t;

  typedef struct packed {
    sub_addr_t addr;
  } sub_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_beat_t;

  typedef struct packed {
    resp_t resp;
  } b_beat_t;

  typedef struct packed {
    host_addr_t addr;
  } host_ar_t;

  typedef struct packed {
    sub_addr_t addr;
  } sub_ar_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_beat_t;

  typedef enum logic [1:0] {WR_IDLE, WR_FWD, WR_RESP, WR_ERR} wr_state_t;
  typedef enum logic [1:0] {RD_IDLE, RD_FWD, RD_RESP, RD_ERR} rd_state_t;

endpackage

`default_nettype wire

// ==== source/axil_router_rd.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_router_rd
  import axil_router_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  input  wire logic                  host_arvalid,
  input  wire host_ar_t              host_ar,
  output      logic                  host_arready,

  output      logic                  host_rvalid,
  output      r_beat_t               host_r,
  input  wire logic                  host_rready,

  output      logic    [NUM_SUB-1:0] sub_arvalid,
  output      sub_ar_t [NUM_SUB-1:0] sub_ar,
  input  wire logic    [NUM_SUB-1:0] sub_arready,

  input  wire logic    [NUM_SUB-1:0] sub_rvalid,
  input  wire r_beat_t [NUM_SUB-1:0] sub_r,
  output      logic    [NUM_SUB-1:0] sub_rready
);

  rd_state_t          state;
  sub_sel_t           sel_q;
  sub_ar_t            ar_q;

  sub_sel_t           host_sel;
  logic               host_mapped;
  logic               accept;
  logic [NUM_SUB-1:0] sel_oh;
  logic               ar_hs;

  assign host_sel    = host_ar.addr[HOST_ADDR_W-1 -: SEL_W];
  assign host_mapped = host_sel < sub_sel_t'(NUM_SUB);

  assign accept       = (state == RD_IDLE) && host_arvalid;
  assign host_arready = accept;

  always_comb begin
    for (int i = 0; i < NUM_SUB; i++) begin
      sel_oh[i] = (sel_q == sub_sel_t'(i));
      sub_ar[i] = ar_q;
    end
  end

  assign sub_arvalid = (state == RD_FWD) ? sel_oh : '0;
  assign ar_hs       = |(sub_arvalid & sub_arready);

  always_comb begin
    host_rvalid = 1'b0;
    host_r      = '{data: '0, resp: RESP_OKAY};
    sub_rready  = '0;
    case (state)
      RD_RESP: begin
        host_rvalid = |(sub_rvalid & sel_oh);
        sub_rready  = host_rready ? sel_oh : '0;
        for (int i = 0; i < NUM_SUB; i++) begin
          if (sel_oh[i]) begin
            host_r = sub_r[i];
          end
        end
      end
      // Unmapped reads get a zero data beat
      RD_ERR: begin
        host_rvalid = 1'b1;
        host_r      = '{data: '0, resp: RESP_DECERR};
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= RD_IDLE;
    end else begin
      case (state)
        RD_IDLE: begin
          if (accept) begin
            state <= host_mapped ? RD_FWD : RD_ERR;
          end
        end
        RD_FWD: begin
          if (ar_hs) begin
            state <= RD_RESP;
          end
        end
        RD_RESP: begin
          if (host_rvalid && host_rready) begin
            state <= RD_IDLE;
          end
        end
        RD_ERR: begin
          if (host_rready) begin
            state <= RD_IDLE;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      sel_q     <= host_sel;
      ar_q.addr <= host_ar.addr[SUB_ADDR_W-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== source/axil_router_wr.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_router_wr
  import axil_router_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  input  wire logic                  host_awvalid,
  input  wire host_aw_t              host_aw,
  output      logic                  host_awready,

  input  wire logic                  host_wvalid,
  input  wire w_beat_t               host_w,
  output      logic                  host_wready,

  output      logic                  host_bvalid,
  output      b_beat_t               host_b,
  input  wire logic                  host_bready,

  output      logic    [NUM_SUB-1:0] sub_awvalid,
  output      sub_aw_t [NUM_SUB-1:0] sub_aw,
  input  wire logic    [NUM_SUB-1:0] sub_awready,

  output      logic    [NUM_SUB-1:0] sub_wvalid,
  output      w_beat_t [NUM_SUB-1:0] sub_w,
  input  wire logic    [NUM_SUB-1:0] sub_wready,

  input  wire logic    [NUM_SUB-1:0] sub_bvalid,
  input  wire b_beat_t [NUM_SUB-1:0] sub_b,
  output      logic    [NUM_SUB-1:0] sub_bready
);

  wr_state_t          state;
  sub_sel_t           sel_q;
  sub_aw_t            aw_q;
  w_beat_t            w_q;
  logic               aw_done;
  logic               w_done;

  sub_sel_t           host_sel;
  logic               host_mapped;
  logic               accept;
  logic [NUM_SUB-1:0] sel_oh;
  logic               aw_hs;
  logic               w_hs;

  assign host_sel    = host_aw.addr[HOST_ADDR_W-1 -: SEL_W];
  assign host_mapped = host_sel < sub_sel_t'(NUM_SUB);

  // AW and W are taken together so the pair can never be split across transactions
  assign accept       = (state == WR_IDLE) && host_awvalid && host_wvalid;
  assign host_awready = accept;
  assign host_wready  = accept;

  always_comb begin
    for (int i = 0; i < NUM_SUB; i++) begin
      sel_oh[i] = (sel_q == sub_sel_t'(i));
      sub_aw[i] = aw_q;
      sub_w[i]  = w_q;
    end
  end

  // Each channel drops on its own handshake, in either order
  assign sub_awvalid = (state == WR_FWD && !aw_done) ? sel_oh : '0;
  assign sub_wvalid  = (state == WR_FWD && !w_done) ? sel_oh : '0;
  assign aw_hs       = |(sub_awvalid & sub_awready);
  assign w_hs        = |(sub_wvalid & sub_wready);

  always_comb begin
    host_bvalid = 1'b0;
    host_b      = '{resp: RESP_OKAY};
    sub_bready  = '0;
    case (state)
      WR_RESP: begin
        host_bvalid = |(sub_bvalid & sel_oh);
        sub_bready  = host_bready ? sel_oh : '0;
        for (int i = 0; i < NUM_SUB; i++) begin
          if (sel_oh[i]) begin
            host_b = sub_b[i];
          end
        end
      end
      WR_ERR: begin
        host_bvalid = 1'b1;
        host_b      = '{resp: RESP_DECERR};
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= WR_IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (accept) begin
            state   <= host_mapped ? WR_FWD : WR_ERR;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end
        end
        WR_FWD: begin
          aw_done <= aw_done | aw_hs;
          w_done  <= w_done | w_hs;
          if ((aw_done || aw_hs) && (w_done || w_hs)) begin
            state <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (host_bvalid && host_bready) begin
            state <= WR_IDLE;
          end
        end
        WR_ERR: begin
          if (host_bready) begin
            state <= WR_IDLE;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // Select bits are stripped here so the subordinate sees only its own offset
  always_ff @(posedge clk) begin
    if (accept) begin
      sel_q     <= host_sel;
      aw_q.addr <= host_aw.addr[SUB_ADDR_W-1:0];
      w_q       <= host_w;
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
source/axil_router_pkg.sv
source/axil_router_wr.sv
source/axil_router_rd.sv
source/axil_router.sv
tb/axil_router_assertions.sv
tb/axil_router_tb.sv

// ==== tb/axil_router_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_router_assertions
  import axil_router_pkg::*;
(
  input wire logic               clk,
  input wire logic               rst_n,
  input wire logic               accept,
  input wire logic               mapped,
  input wire logic [NUM_SUB-1:0] sub_valid,
  input wire logic [NUM_SUB-1:0] sub_ready,
  input wire sub_addr_t          sub_addr,
  input wire logic               host_valid,
  input wire logic               host_ready,
  input wire resp_t              host_resp
);

  a_quiet_after_reset: assert property (@(posedge clk)
    !rst_n |=> (sub_valid == '0 && !host_valid))
    else $error("valid output high during or right after reset");

  a_sub_hold: assert property (@(posedge clk) disable iff (!rst_n)
    |(sub_valid & ~sub_ready) |=> (sub_valid == $past(sub_valid) && $stable(sub_addr)))
    else $error("subordinate valid or address changed before ready");

  a_host_hold: assert property (@(posedge clk) disable iff (!rst_n)
    host_valid && !host_ready |=> host_valid && $stable(host_resp))
    else $error("host response valid or payload changed before ready");

  a_one_sub: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(sub_valid))
    else $error("more than one subordinate valid");

  a_fwd: assert property (@(posedge clk) disable iff (!rst_n)
    accept && mapped |=> |sub_valid)
    else $error("mapped acceptance not forwarded next cycle");

  a_decerr: assert property (@(posedge clk) disable iff (!rst_n)
    accept && !mapped |=> host_valid && host_resp == RESP_DECERR)
    else $error("unmapped acceptance did not answer DECERR");

endmodule

bind axil_router_wr axil_router_assertions wr_chk_i (.clk(clk), .rst_n(rst_n),
  .accept(accept), .mapped(host_mapped), .sub_valid(sub_awvalid), .sub_ready(sub_awready),
  .sub_addr(sub_aw[0].addr), .host_valid(host_bvalid), .host_ready(host_bready),
  .host_resp(host_b.resp));

bind axil_router_rd axil_router_assertions rd_chk_i (.clk(clk), .rst_n(rst_n),
  .accept(accept), .mapped(host_mapped), .sub_valid(sub_arvalid), .sub_ready(sub_arready),
  .sub_addr(sub_ar[0].addr), .host_valid(host_rvalid), .host_ready(host_rready),
  .host_resp(host_r.resp));

`default_nettype wire

// ==== tb/axil_router_patterns.txt ====
# op host_addr data strb sub_resp exp_resp exp_rdata (all hex, op is w or r)
# sub_resp is what the subordinate model answers, exp_rdata is ignored for writes
w 00000010 11223344 f 0 0 00000000
w 10000124 a5a5a5a5 3 0 0 00000000
w 2ffffffc deadbeef c 0 0 00000000
w 0abcdef0 01020304 1 2 2 00000000
w 30000000 55aa55aa f 0 3 00000000
r 00000010 cafef00d 0 0 0 cafef00d
r 10000124 12345678 0 0 0 12345678
r 2ffffffc 87654321 0 0 0 87654321
r 3fffffff 99999999 0 0 3 00000000
r 20000040 0badc0de 0 2 2 0badc0de
w 1fffffff ffffffff f 0 0 00000000
w 20000000 00000000 0 0 0 00000000
w 3abcdef0 13572468 5 0 3 00000000
r 0fffffff 00000001 0 0 0 00000001
r 1000000c fedcba98 0 0 0 fedcba98
w 00000004 10203040 6 2 2 00000000
w 12345678 c0ffee00 9 0 0 00000000
r 30000010 44444444 0 0 3 00000000
r 00000000 76543210 0 2 2 76543210
w 25a5a5a4 a1b2c3d4 f 0 0 00000000
r 25a5a5a4 a1b2c3d4 0 0 0 a1b2c3d4
w 0000abcd 0f0f0f0f a 0 0 00000000
r 1f00ff00 5a5a5a5a 0 0 0 5a5a5a5a
w 2f0f0f0c 3c3c3c3c f 2 2 00000000
r 2f0f0f0c 3c3c3c3c 0 0 0 3c3c3c3c
w 3fffffff 77777777 f 2 3 00000000
r 00000ff0 e0e0e0e0 0 0 0 e0e0e0e0
w 10000000 89abcdef 8 0 0 00000000

// ==== tb/axil_router_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_router_tb
  import axil_router_pkg::*;
();

  localparam int TIMEOUT = 50;

  logic clk = 1'b0;
  logic rst_n;

  logic host_awvalid, host_awready, host_wvalid, host_wready, host_bvalid, host_bready;
  logic host_arvalid, host_arready, host_rvalid, host_rready;
  host_aw_t host_aw;
  w_beat_t  host_w;
  b_beat_t  host_b;
  host_ar_t host_ar;
  r_beat_t  host_r;

  logic    [NUM_SUB-1:0] sub_awvalid, sub_awready, sub_wvalid, sub_wready;
  logic    [NUM_SUB-1:0] sub_bvalid, sub_bready, sub_arvalid, sub_arready;
  logic    [NUM_SUB-1:0] sub_rvalid, sub_rready;
  sub_aw_t [NUM_SUB-1:0] sub_aw;
  w_beat_t [NUM_SUB-1:0] sub_w;
  b_beat_t [NUM_SUB-1:0] sub_b;
  sub_ar_t [NUM_SUB-1:0] sub_ar;
  r_beat_t [NUM_SUB-1:0] sub_r;

  // Index of the one subordinate allowed to see a valid or 3 for none
  sub_sel_t  wr_exp_sel;
  sub_sel_t  rd_exp_sel;
  sub_addr_t got_aw_addr;
  sub_addr_t got_ar_addr;
  data_t     got_wdata;
  strb_t     got_wstrb;

  axil_router dut_i (.*);

  always #10 clk = ~clk;

  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
    fail_run();
  endtask

  task automatic check_sub_addr(input string name, input sub_addr_t exp, input sub_addr_t got);
    if (got !== exp) begin
      $display("error %s expected %h got %h", name, exp, got);
      fail_run();
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t got);
    if (got !== exp) begin
      $display("error %s expected %h got %h", name, exp, got);
      fail_run();
    end
  endtask

  task automatic check_strb(input string name, input strb_t exp, input strb_t got);
    if (got !== exp) begin
      $display("error %s expected %h got %h", name, exp, got);
      fail_run();
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t got);
    if (got !== exp) begin
      $display("error %s expected %h got %h", name, exp, got);
      fail_run();
    end
  endtask

  task automatic check_sel(input string name, input sub_sel_t exp, input sub_sel_t got);
    if (got !== exp) begin
      $display("error %s expected %h got %h", name, exp, got);
      fail_run();
    end
  endtask

  function automatic int pick_delay();
    return int'($urandom % 4);
  endfunction

  // Only the addressed subordinate may ever see a valid
  always @(negedge clk) begin
    if (rst_n) begin
      for (int i = 0; i < NUM_SUB; i++) begin
        if (sub_awvalid[i] || sub_wvalid[i]) begin
          check_sel("sub_awvalid/sub_wvalid index", wr_exp_sel, sub_sel_t'(i));
        end
        if (sub_arvalid[i]) begin
          check_sel("sub_arvalid index", rd_exp_sel, sub_sel_t'(i));
        end
      end
    end
  end

  task automatic serve_aw(input int sel);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout("sub_awvalid");
    end while (!sub_awvalid[sel]);
    repeat (pick_delay()) @(posedge clk);
    @(posedge clk);
    #2;
    sub_awready[sel] = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout("the AW handshake at the subordinate");
    end while (!(sub_awvalid[sel] && sub_awready[sel]));
    got_aw_addr = sub_aw[sel].addr;
    @(posedge clk);
    #2;
    sub_awready[sel] = 1'b0;
  endtask

  task automatic serve_w(input int sel);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout("sub_wvalid");
    end while (!sub_wvalid[sel]);
    repeat (pick_delay()) @(posedge clk);
    @(posedge clk);
    #2;
    sub_wready[sel] = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout("the W handshake at the subordinate");
    end while (!(sub_wvalid[sel] && sub_wready[sel]));
    got_wdata = sub_w[sel].data;
    got_wstrb = sub_w[sel].strb;
    @(posedge clk);
    #2;
    sub_wready[sel] = 1'b0;
  endtask

  task automatic serve_b(input int sel, input resp_t resp);
    int n;
    repeat (pick_delay()) @(posedge clk);
    @(posedge clk);
    #2;
    sub_bvalid[sel]  = 1'b1;
    sub_b[sel].resp  = resp;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout("sub_bready from the router");
    end while (!sub_bready[sel]);
    @(posedge clk);
    #2;
    sub_bvalid[sel] = 1'b0;
  endtask

  task automatic serve_ar_r(input int sel, input data_t data, input resp_t resp);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout("sub_arvalid");
    end while (!sub_arvalid[sel]);
    repeat (pick_delay()) @(posedge clk);
    @(posedge clk);
    #2;
    sub_arready[sel] = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout("the AR handshake at the subordinate");
    end while (!(sub_arvalid[sel] && sub_arready[sel]));
    got_ar_addr = sub_ar[sel].addr;
    @(posedge clk);
    #2;
    sub_arready[sel] = 1'b0;
    repeat (pick_delay()) @(posedge clk);
    @(posedge clk);
    #2;
    sub_rvalid[sel]     = 1'b1;
    sub_r[sel].data     = data;
    sub_r[sel].resp     = resp;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout("sub_rready from the router");
    end while (!sub_rready[sel]);
    @(posedge clk);
    #2;
    sub_rvalid[sel] = 1'b0;
  endtask

  task automatic host_write(input host_addr_t addr, input data_t data, input strb_t strb,
                            output resp_t resp);
    int n;
    @(posedge clk);
    #2;
    host_awvalid  = 1'b1;
    host_aw.addr  = addr;
    host_wvalid   = 1'b1;
    host_w.data   = data;
    host_w.strb   = strb;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout("host_awready and host_wready");
    end while (!(host_awready && host_wready));
    @(posedge clk);
    #2;
    host_awvalid = 1'b0;
    host_wvalid  = 1'b0;
    // Back-pressure on B for a few cycles
    repeat (pick_delay() + 2) @(posedge clk);
    #2;
    host_bready = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout("host_bvalid");
    end while (!host_bvalid);
    resp = host_b.resp;
    @(posedge clk);
    #2;
    host_bready = 1'b0;
  endtask

  task automatic host_read(input host_addr_t addr, output data_t data, output resp_t resp);
    int n;
    @(posedge clk);
    #2;
    host_arvalid = 1'b1;
    host_ar.addr = addr;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout("host_arready");
    end while (!host_arready);
    @(posedge clk);
    #2;
    host_arvalid = 1'b0;
    repeat (pick_delay() + 2) @(posedge clk);
    #2;
    host_rready = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) timeout("host_rvalid");
    end while (!host_rvalid);
    data = host_r.data;
    resp = host_r.resp;
    @(posedge clk);
    #2;
    host_rready = 1'b0;
  endtask

  initial begin
    string      line;
    string      op;
    int         fd;
    int         fields;
    int         sel;
    int         count;
    host_addr_t addr;
    sub_addr_t  exp_sub_addr;
    data_t      data;
    data_t      exp_rdata;
    data_t      got_rdata;
    strb_t      strb;
    resp_t      sub_resp;
    resp_t      exp_resp;
    resp_t      got_resp;

    void'($urandom(32'h4a25d32f));
    rst_n        = 1'b0;
    host_awvalid = 1'b0;
    host_aw      = '0;
    host_wvalid  = 1'b0;
    host_w       = '0;
    host_bready  = 1'b0;
    host_arvalid = 1'b0;
    host_ar      = '0;
    host_rready  = 1'b0;
    sub_awready  = '0;
    sub_wready   = '0;
    sub_bvalid   = '0;
    sub_b        = '0;
    sub_arready  = '0;
    sub_rvalid   = '0;
    sub_r        = '0;
    wr_exp_sel   = 2'd3;
    rd_exp_sel   = 2'd3;
    count        = 0;

    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    if (host_bvalid || host_rvalid || (|sub_awvalid) || (|sub_wvalid) || (|sub_arvalid)) begin
      $display("Valid outputs were not low after reset");
      fail_run();
    end

    fd = $fopen("tb/axil_router_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file tb/axil_router_patterns.txt");
      fail_run();
    end

    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      fields = $sscanf(line, "%s %h %h %h %h %h %h", op, addr, data, strb, sub_resp,
                       exp_resp, exp_rdata);
      if (fields != 7) begin
        $display("Pattern line could not be parsed: %s", line);
        fail_run();
      end
      // Each subordinate owns one region and sees the offset into it
      sel          = int'(addr >> SUB_ADDR_W);
      exp_sub_addr = sub_addr_t'(addr - (host_addr_t'(sel) << SUB_ADDR_W));
      if (op == "w") begin
        wr_exp_sel = sub_sel_t'(sel);
        fork
          host_write(addr, data, strb, got_resp);
          begin
            if (sel < NUM_SUB) begin
              fork
                serve_aw(sel);
                serve_w(sel);
              join
              serve_b(sel, sub_resp);
            end
          end
        join
        wr_exp_sel = 2'd3;
        if (sel < NUM_SUB) begin
          check_sub_addr("sub_aw.addr", exp_sub_addr, got_aw_addr);
          check_data("sub_w.data", data, got_wdata);
          check_strb("sub_w.strb", strb, got_wstrb);
        end
        check_resp("host_b.resp", exp_resp, got_resp);
      end else begin
        rd_exp_sel = sub_sel_t'(sel);
        fork
          host_read(addr, got_rdata, got_resp);
          begin
            if (sel < NUM_SUB) serve_ar_r(sel, data, sub_resp);
          end
        join
        rd_exp_sel = 2'd3;
        if (sel < NUM_SUB) begin
          check_sub_addr("sub_ar.addr", exp_sub_addr, got_ar_addr);
        end
        check_data("host_r.data", exp_rdata, got_rdata);
        check_resp("host_r.resp", exp_resp, got_resp);
      end
      count++;
    end
    $fclose(fd);

    if (count == 0) begin
      $display("No transactions were read from the pattern file");
      fail_run();
    end else begin
      $display("%0d transactions checked", count);
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
